/* logic/lcd_cmd_pkg.sv */
`default_nettype none

package lcd_cmd_pkg;

	// display setup bits, upper bit first
	typedef struct packed {
		logic two_lines;   // N, 2-line display
		logic big_font;    // F, 5x10 dots
		logic display_on;  // D
		logic cursor_on;   // C
		logic blink_on;    // B
		logic increment;   // I/D, address moves up
		logic shift;       // S, display shift on write
	} lcd_config_t;

	// instruction bytes and prefixes, rs = 0
	localparam logic [7:0] INSTR_CLEAR     = 8'h01;
	localparam logic [7:0] INSTR_ENTRY     = 8'h04;  // 0000_01 I/D S
	localparam logic [7:0] INSTR_DISPLAY   = 8'h08;  // 0000_1 D C B
	localparam logic [7:0] INSTR_FUNCTION  = 8'h30;  // 001 DL=1, then N F
	localparam logic [7:0] INSTR_SET_DDRAM = 8'h80;  // top bit, address below

	// power-up wake-up, function set with 8-bit bus and nothing else
	localparam logic [7:0] WAKEUP_BYTE = 8'h30;

	// control codes from the host
	localparam logic [7:0] CHAR_NEWLINE = 8'h0A;
	localparam logic [7:0] CHAR_CLEAR   = 8'h0C;

	// 2x16 geometry
	localparam int         COLUMNS    = 16;
	localparam logic [6:0] LINE2_BASE = 7'h40;  // ddram start of line 2

endpackage

`default_nettype wire

/* logic/lcd_timing_pkg.sv */
`default_nettype none

package lcd_timing_pkg;

	// module timing in microseconds
	localparam int T_POWER_UP_US    = 500;   // wait after supply comes up
	localparam int T_SETUP_US       = 1;     // rs/data setup before e rises
	localparam int T_ENABLE_HIGH_US = 13;    // e high time
	localparam int T_CYCLE_US       = 50;    // one ordinary instruction or data write
	localparam int T_CLEAR_US       = 1640;  // clear display runs much longer

	// microseconds to clock cycles; at least one cycle so every phase exists
	function automatic int cycles_of(input int time_us, input int clk_per_us);
		int n;
		n = time_us * clk_per_us;
		if (n < 1)
			n = 1;
		return n;
	endfunction

endpackage

`default_nettype wire

/* logic/lcd_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

// one bus write, four-phase req/ack
interface lcd_req_if;

	logic       req;
	logic       rs;    // 0 instruction, 1 character data
	logic [7:0] data;
	logic       ack;

	// writer side
	modport master (
		output req,
		output rs,
		output data,
		input  ack
	);

	// driver side
	modport slave (
		input  req,
		input  rs,
		input  data,
		output ack
	);

endinterface

`default_nettype wire

/* logic/lcd_bus_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_driver #(
	parameter int CLK_PER_US = 3
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire lcd_cmd_pkg::lcd_config_t cfg,
	lcd_req_if.slave                 bus,
	output logic                     ready,
	output logic                     e,
	output logic                     rs,
	output logic                     rw,
	output logic [7:0]               lcd_data
);

	localparam int C_POWER_UP = lcd_timing_pkg::cycles_of(lcd_timing_pkg::T_POWER_UP_US,
		CLK_PER_US);
	localparam int C_SETUP = lcd_timing_pkg::cycles_of(lcd_timing_pkg::T_SETUP_US, CLK_PER_US);
	localparam int C_HIGH = lcd_timing_pkg::cycles_of(lcd_timing_pkg::T_ENABLE_HIGH_US,
		CLK_PER_US);
	localparam int C_CYCLE = lcd_timing_pkg::cycles_of(lcd_timing_pkg::T_CYCLE_US, CLK_PER_US);
	localparam int C_CLEAR = lcd_timing_pkg::cycles_of(lcd_timing_pkg::T_CLEAR_US, CLK_PER_US);

	// clear is the longest wait, longer than power-up as well
	localparam int CNT_W = $clog2(C_CLEAR + 1);

	localparam logic [CNT_W-1:0] POWER_UP_LAST = CNT_W'(C_POWER_UP - 1);
	localparam logic [CNT_W-1:0] E_RISE        = CNT_W'(C_SETUP);
	localparam logic [CNT_W-1:0] E_FALL        = CNT_W'(C_SETUP + C_HIGH);
	localparam logic [CNT_W-1:0] HOLD_CYCLE    = CNT_W'(C_CYCLE - 1);
	localparam logic [CNT_W-1:0] HOLD_CLEAR    = CNT_W'(C_CLEAR - 1);

	localparam logic [2:0] STEP_CLEAR = 3'd3;
	localparam logic [2:0] STEP_LAST  = 3'd4;

	typedef enum logic [2:0] {
		s_power_up,
		s_init,
		s_idle,
		s_write,
		s_release
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;
	logic [CNT_W-1:0] hold_last;  // last count of the running write
	logic [2:0]       step;       // init sequence position
	logic [7:0]       init_byte;

	assign rw = 1'b0;  // write only, busy flag never read
	assign cnt_next = cnt + 1'b1;

	always_comb begin
		case (step)
			3'd0: init_byte = lcd_cmd_pkg::WAKEUP_BYTE;
			3'd1: init_byte = lcd_cmd_pkg::INSTR_FUNCTION | {4'b0000, cfg.two_lines, cfg.big_font, 2'b00};
			3'd2: init_byte = lcd_cmd_pkg::INSTR_DISPLAY |
				{5'b00000, cfg.display_on, cfg.cursor_on, cfg.blink_on};
			3'd3: init_byte = lcd_cmd_pkg::INSTR_CLEAR;
			default: init_byte = lcd_cmd_pkg::INSTR_ENTRY | {6'b000000, cfg.increment, cfg.shift};
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= s_power_up;
			cnt      <= '0;
			step     <= '0;
			ready    <= 1'b0;
			e        <= 1'b0;
			rs       <= 1'b0;
			lcd_data <= '0;
			bus.ack  <= 1'b0;
		end else begin
			case (state)
				s_power_up: begin
					if (cnt == POWER_UP_LAST) begin
						cnt   <= '0;
						state <= s_init;
					end else begin
						cnt <= cnt_next;
					end
				end
				s_init: begin
					rs        <= 1'b0;
					lcd_data  <= init_byte;
					hold_last <= (step == STEP_CLEAR) ? HOLD_CLEAR : HOLD_CYCLE;
					cnt       <= '0;
					state     <= s_write;
				end
				s_idle: begin
					if (bus.req) begin
						rs        <= bus.rs;  // pins follow the request at once
						lcd_data  <= bus.data;
						hold_last <= (!bus.rs && bus.data == lcd_cmd_pkg::INSTR_CLEAR) ?
							HOLD_CLEAR : HOLD_CYCLE;
						cnt       <= '0;
						state     <= s_write;
					end
				end
				s_write: begin
					e <= (cnt_next >= E_RISE) && (cnt_next < E_FALL);  // setup, then high pulse
					if (cnt == hold_last) begin
						cnt <= '0;
						if (ready) begin
							bus.ack <= 1'b1;
							state   <= s_release;
						end else if (step == STEP_LAST) begin
							ready <= 1'b1;  // entry mode done, init over
							state <= s_idle;
						end else begin
							step  <= step + 1'b1;
							state <= s_init;
						end
					end else begin
						cnt <= cnt_next;
					end
				end
				s_release: begin
					if (!bus.req) begin
						bus.ack <= 1'b0;
						state   <= s_idle;
					end
				end
				default: state <= s_power_up;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/lcd_text_writer.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_text_writer (
	input  wire        clk,
	input  wire        reset,
	input  wire        ready,
	input  wire  [7:0] char_code,
	input  wire        char_req,
	output logic       char_ack,
	lcd_req_if.master  bus
);

	localparam logic [4:0] LAST_COL = 5'(lcd_cmd_pkg::COLUMNS);

	typedef enum logic [1:0] {
		s_idle,
		s_req,   // req high, waiting for ack
		s_gap,   // req low, waiting for ack to drop
		s_done   // char_ack high until host lets go
	} state_t;

	state_t     state;
	logic       line;          // 0 first line, 1 second line
	logic [4:0] col;           // 16 means past the end of the line
	logic       char_pending;  // character still due after an address write
	logic [6:0] other_base;

	assign other_base = line ? 7'h00 : lcd_cmd_pkg::LINE2_BASE;

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= s_idle;
			line         <= 1'b0;
			col          <= '0;
			char_pending <= 1'b0;
			char_ack     <= 1'b0;
			bus.req      <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					if (ready && char_req) begin
						bus.req <= 1'b1;
						state   <= s_req;
						if (char_code == lcd_cmd_pkg::CHAR_CLEAR) begin
							bus.rs       <= 1'b0;
							bus.data     <= lcd_cmd_pkg::INSTR_CLEAR;
							line         <= 1'b0;
							col          <= '0;
							char_pending <= 1'b0;
						end else if (char_code == lcd_cmd_pkg::CHAR_NEWLINE || col == LAST_COL) begin
							// jump to the start of the other line
							bus.rs       <= 1'b0;
							bus.data     <= lcd_cmd_pkg::INSTR_SET_DDRAM | {1'b0, other_base};
							line         <= ~line;
							col          <= '0;
							char_pending <= (char_code != lcd_cmd_pkg::CHAR_NEWLINE);
						end else begin
							bus.rs       <= 1'b1;
							bus.data     <= char_code;
							col          <= col + 1'b1;  // module auto-increments too
							char_pending <= 1'b0;
						end
					end
				end
				s_req: begin
					if (bus.ack) begin
						bus.req <= 1'b0;
						state   <= s_gap;
					end
				end
				s_gap: begin
					if (!bus.ack) begin
						if (char_pending) begin
							bus.rs       <= 1'b1;
							bus.data     <= char_code;  // host still holds it
							col          <= col + 1'b1;
							char_pending <= 1'b0;
							bus.req      <= 1'b1;
							state        <= s_req;
						end else begin
							char_ack <= 1'b1;
							state    <= s_done;
						end
					end
				end
				s_done: begin
					if (!char_req) begin
						char_ack <= 1'b0;
						state    <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/lcd_display_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_display_top #(
	parameter int CLK_PER_US = 3
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire lcd_cmd_pkg::lcd_config_t cfg,
	input  wire  [7:0]               char_code,
	input  wire                      char_req,
	output wire                      char_ack,
	output wire                      ready,
	output wire                      e,
	output wire                      rs,
	output wire                      rw,
	output wire  [7:0]               lcd_data
);

	lcd_req_if req_bus ();  // writer to driver

	lcd_text_writer u_writer (
		.clk       (clk),
		.reset     (reset),
		.ready     (ready),  // holds the host off until init is done
		.char_code (char_code),
		.char_req  (char_req),
		.char_ack  (char_ack),
		.bus       (req_bus.master)
	);

	lcd_bus_driver #(
		.CLK_PER_US (CLK_PER_US)
	) u_driver (
		.clk      (clk),
		.reset    (reset),
		.cfg      (cfg),
		.bus      (req_bus.slave),
		.ready    (ready),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data)
	);

endmodule

`default_nettype wire

/* verification/lcd_display_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_display_tb;

	localparam int CLK_PER_US    = 3;
	localparam int C_POWER_UP    = lcd_timing_pkg::T_POWER_UP_US * CLK_PER_US;
	localparam int C_HIGH        = lcd_timing_pkg::T_ENABLE_HIGH_US * CLK_PER_US;
	localparam int READY_TIMEOUT = 20000;  // init needs about 7100 cycles
	localparam int ACK_TIMEOUT   = 12000;  // covers clear plus an address write
	localparam int DROP_TIMEOUT  = 50;
	localparam int N_RANDOM      = 60;

	logic                     clk;
	logic                     reset;
	lcd_cmd_pkg::lcd_config_t cfg;
	logic [7:0]               char_code;
	logic                     char_req;
	wire                      char_ack;
	wire                      ready;
	wire                      e;
	wire                      rs;
	wire                      rw;
	wire  [7:0]               lcd_data;

	// lcd bus model
	logic [8:0] cap_q[$];        // {rs, data} per falling edge of e
	int         cap_total;
	logic [6:0] ddram_addr;
	logic [6:0] last_data_addr;  // where the latest character landed
	logic       prev_e;
	logic       prev_ack;
	logic       hold_rs;
	logic [7:0] hold_data;
	int         high_cnt;
	int         cyc;
	bit         seen_e;

	// reference cursor and expected writes
	logic [8:0] exp_q[$];
	logic       ref_line;
	int         ref_col;

	lcd_display_top #(
		.CLK_PER_US (CLK_PER_US)
	) dut (
		.clk       (clk),
		.reset     (reset),
		.cfg       (cfg),
		.char_code (char_code),
		.char_req  (char_req),
		.char_ack  (char_ack),
		.ready     (ready),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic mismatch_stop(input string name, input int expected, input int actual);
		$display("FAILED at %0t: %s expected 0x%0h, actual 0x%0h",
			$time, name, expected, actual);
		$display("Done: errors found");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic abort_run(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1, "%s", msg);
	endtask

	// what the module does with one captured write
	task automatic model_write(input logic rs_v, input logic [7:0] data_v);
		cap_q.push_back({rs_v, data_v});
		cap_total++;
		if (rs_v) begin
			last_data_addr = ddram_addr;
			ddram_addr     = ddram_addr + 1'b1;  // increment mode
		end else if (data_v == lcd_cmd_pkg::INSTR_CLEAR) begin
			ddram_addr = '0;
		end else if (data_v[7]) begin
			ddram_addr = data_v[6:0];
		end
	endtask

	// bus model and protocol checks on the falling edge
	always @(negedge clk) begin
		if (reset) begin
			cyc        = 0;
			prev_e     = 1'b0;
			prev_ack   = 1'b0;
			seen_e     = 1'b0;
			ddram_addr = '0;
		end else begin
			cyc++;
			assert (rw == 1'b0) else mismatch_stop("rw", 0, rw);
			if (char_ack && !prev_ack) begin
				assert (char_req) else abort_run("char_ack rose while char_req was low");
			end
			if (!char_ack && prev_ack) begin
				assert (!char_req) else abort_run("char_ack fell before char_req fell");
			end
			if (e && !prev_e) begin
				if (!seen_e) begin
					assert (cyc >= C_POWER_UP)
						else abort_run("e pulse during the power-up wait");
				end
				seen_e    = 1'b1;
				hold_rs   = rs;
				hold_data = lcd_data;
				high_cnt  = 1;
			end else if (e) begin
				high_cnt++;
				assert (rs == hold_rs) else mismatch_stop("rs while e high", hold_rs, rs);
				assert (lcd_data == hold_data)
					else mismatch_stop("lcd_data while e high", hold_data, lcd_data);
			end else if (prev_e) begin
				assert (high_cnt == C_HIGH)
					else mismatch_stop("e high cycles", C_HIGH, high_cnt);
				if (cap_total < 5) begin
					assert (!ready) else abort_run("ready high before init finished");
				end
				model_write(rs, lcd_data);
			end
			prev_e   = e;
			prev_ack = char_ack;
		end
	end

	// expected bus writes for one host character
	task automatic predict_char(input logic [7:0] c);
		logic [6:0] other;
		other = ref_line ? 7'h00 : lcd_cmd_pkg::LINE2_BASE;
		if (c == lcd_cmd_pkg::CHAR_CLEAR) begin
			exp_q.push_back({1'b0, lcd_cmd_pkg::INSTR_CLEAR});
			ref_line = 1'b0;
			ref_col  = 0;
		end else if (c == lcd_cmd_pkg::CHAR_NEWLINE) begin
			exp_q.push_back({1'b0, 1'b1, other});  // set ddram address
			ref_line = ~ref_line;
			ref_col  = 0;
		end else begin
			if (ref_col == lcd_cmd_pkg::COLUMNS) begin  // line full so jump first
				exp_q.push_back({1'b0, 1'b1, other});
				ref_line = ~ref_line;
				ref_col  = 0;
			end
			exp_q.push_back({1'b1, c});
			ref_col++;
		end
	endtask

	task automatic check_writes(input logic [7:0] c);
		logic [8:0] exp_w;
		logic [8:0] got_w;
		logic [6:0] ref_addr;
		assert (cap_q.size() == exp_q.size())
			else mismatch_stop("bus write count", exp_q.size(), cap_q.size());
		while (exp_q.size() > 0) begin
			exp_w = exp_q.pop_front();
			got_w = cap_q.pop_front();
			assert (got_w[8] == exp_w[8]) else mismatch_stop("rs", exp_w[8], got_w[8]);
			assert (got_w[7:0] == exp_w[7:0])
				else mismatch_stop("lcd_data", exp_w[7:0], got_w[7:0]);
		end
		ref_addr = (ref_line ? lcd_cmd_pkg::LINE2_BASE : 7'h00) + 7'(ref_col);
		assert (ddram_addr == ref_addr)
			else mismatch_stop("ddram address", ref_addr, ddram_addr);
		if (c != lcd_cmd_pkg::CHAR_CLEAR && c != lcd_cmd_pkg::CHAR_NEWLINE) begin
			assert (last_data_addr == ref_addr - 1'b1)
				else mismatch_stop("character address", ref_addr - 1'b1, last_data_addr);
		end
	endtask

	// one four-phase host transfer
	task automatic send_char(input logic [7:0] c);
		int t;
		predict_char(c);
		@(posedge clk);
		char_code <= c;
		char_req  <= 1'b1;
		for (t = 0; t < ACK_TIMEOUT; t++) begin
			@(negedge clk);
			if (char_ack)
				break;
		end
		if (!char_ack)
			abort_run("char_ack did not rise before the timeout");
		check_writes(c);
		@(posedge clk);
		char_req <= 1'b0;
		for (t = 0; t < DROP_TIMEOUT; t++) begin
			@(negedge clk);
			if (!char_ack)
				break;
		end
		if (char_ack)
			abort_run("char_ack did not fall after char_req fell");
	endtask

	task automatic wait_ready;
		int t;
		for (t = 0; t < READY_TIMEOUT; t++) begin
			@(negedge clk);
			if (ready)
				break;
		end
		if (!ready)
			abort_run("ready did not rise before the timeout");
	endtask

	task automatic check_init;
		logic [8:0] init_exp[5];
		logic [8:0] got_w;
		int         i;
		init_exp[0] = 9'h030;  // wake-up with 8-bit bus
		init_exp[1] = {1'b0, 4'b0011, cfg.two_lines, cfg.big_font, 2'b00};  // 001 DL N F x x
		init_exp[2] = {1'b0, 5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink_on};
		init_exp[3] = 9'h001;  // clear display
		init_exp[4] = {1'b0, 6'b000001, cfg.increment, cfg.shift};
		assert (cap_total == 5) else mismatch_stop("init write count", 5, cap_total);
		for (i = 0; i < 5; i++) begin
			got_w = cap_q.pop_front();
			assert (got_w == init_exp[i])
				else mismatch_stop("init {rs, lcd_data}", init_exp[i], got_w);
		end
	endtask

	initial begin
		int         i;
		int         r;
		logic [7:0] c;
		void'($urandom(1309));
		reset          = 1'b1;
		char_req       = 1'b0;
		char_code      = 8'h00;
		cfg.two_lines  = 1'b1;
		cfg.big_font   = 1'b0;
		cfg.display_on = 1'b1;
		cfg.cursor_on  = 1'b1;
		cfg.blink_on   = 1'b0;
		cfg.increment  = 1'b1;  // cursor model relies on this
		cfg.shift      = 1'b0;
		cap_total      = 0;
		ref_line       = 1'b0;
		ref_col        = 0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		assert (e == 1'b0) else mismatch_stop("e", 0, e);
		assert (rs == 1'b0) else mismatch_stop("rs", 0, rs);
		assert (rw == 1'b0) else mismatch_stop("rw", 0, rw);
		assert (lcd_data == 8'h00) else mismatch_stop("lcd_data", 0, lcd_data);
		assert (ready == 1'b0) else mismatch_stop("ready", 0, ready);
		assert (char_ack == 1'b0) else mismatch_stop("char_ack", 0, char_ack);

		wait_ready();
		check_init();

		// 17 characters force the wrap to line 2
		for (i = 0; i < 17; i++)
			send_char(8'h41 + 8'(i));
		send_char(lcd_cmd_pkg::CHAR_NEWLINE);
		send_char("H");
		send_char("i");
		send_char(lcd_cmd_pkg::CHAR_CLEAR);
		send_char("Z");  // lands at address 0
		send_char(lcd_cmd_pkg::CHAR_NEWLINE);

		// 17 more wrap line 2 back to line 1
		for (i = 0; i < 17; i++)
			send_char(8'h61 + 8'(i));

		// random text with control codes and host idle gaps
		for (i = 0; i < N_RANDOM; i++) begin
			r = $urandom % 16;
			if (r == 0)
				c = lcd_cmd_pkg::CHAR_CLEAR;
			else if (r == 1)
				c = lcd_cmd_pkg::CHAR_NEWLINE;
			else
				c = 8'h20 + 8'($urandom % 95);
			send_char(c);
			repeat ($urandom % 4) @(posedge clk);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
logic/lcd_cmd_pkg.sv
logic/lcd_timing_pkg.sv
logic/lcd_req_if.sv
logic/lcd_bus_driver.sv
logic/lcd_text_writer.sv
logic/lcd_display_top.sv
verification/lcd_display_tb.sv

/* Bender.yml */
package:
  name: lcd_display

sources:
  - logic/lcd_cmd_pkg.sv
  - logic/lcd_timing_pkg.sv
  - logic/lcd_req_if.sv
  - logic/lcd_bus_driver.sv
  - logic/lcd_text_writer.sv
  - logic/lcd_display_top.sv
  - target: test
    files:
      - verification/lcd_display_tb.sv
